// File: source/ddr3_app_pkg.sv
package ddr3_app_pkg;

    // ******************************
    // memory user interface widths
    // ******************************

    // rank bit, burst index, column bits
    localparam int app_addr_w = 27;

    // column bits below the burst index, always zero
    localparam int app_col_w  = 3;

    // one burst of 8 x 16-bit words
    localparam int app_data_w = 128;

    localparam int app_cmd_w  = 3;

    // ******************************
    // user interface types
    // ******************************

    // command address as seen by the memory
    typedef logic [app_addr_w-1:0] app_addr_t;

    // one full burst of write or read data
    typedef logic [app_data_w-1:0] app_data_t;

    // command code on app_cmd
    typedef logic [app_cmd_w-1:0]  app_cmd_t;

    // ******************************
    // command codes
    // ******************************

    localparam app_cmd_t app_cmd_write = 3'b000;
    localparam app_cmd_t app_cmd_read  = 3'b001;

endpackage

// File: source/ddr3_ctrl_pkg.sv
package ddr3_ctrl_pkg;

    // ******************************
    // burst addressing
    // ******************************

    // index of a 128-bit burst in memory
    localparam int burst_idx_w = 23;

    // number of bursts in one readout
    localparam int burst_cnt_w = 24;

    typedef logic [burst_idx_w-1:0] burst_idx_t;

    typedef logic [burst_cnt_w-1:0] burst_cnt_t;

    // ******************************
    // command arbiter states
    // ******************************

    // idle waits for a request
    // write and read hold the grant until app_rdy
    typedef enum logic [1:0] {
        arb_idle,
        arb_write,
        arb_read
    } arb_state_t;

endpackage

// File: source/app_req_if.sv
interface app_req_if
    import ddr3_ctrl_pkg::*;
();

    // write request from the acquisition side
    burst_idx_t wr_addr;
    logic       wr_en;
    // high in the cycle the write command is taken
    logic       wr_rdy;

    // read request from the readout side
    burst_idx_t rd_addr;
    logic       rd_en;
    // high in the cycle the read command is taken
    logic       rd_rdy;

    // write controller side
    modport wr (
        output wr_addr,
        output wr_en,
        input  wr_rdy
    );

    // read controller side
    modport rd (
        output rd_addr,
        output rd_en,
        input  rd_rdy
    );

    // arbiter side, sees both requests
    modport arb (
        input  wr_addr,
        input  wr_en,
        input  rd_addr,
        input  rd_en,
        output wr_rdy,
        output rd_rdy
    );

endinterface

// File: source/ddr3_wr_control.sv
module ddr3_wr_control
    import ddr3_ctrl_pkg::*;
(
    input  logic      ddr3_domain_clk,
    input  logic      rst_n,
    input  logic      acq_enabled,
    input  logic      acq_done,
    input  logic      ddr3_wr_fifo_empty,
    input  logic      app_wdf_rdy,
    output logic      ddr3_wr_fifo_rd_en,
    output logic      app_wdf_wren,
    output logic      app_wdf_end,
    output logic      ddr3_wr_done,
    app_req_if.wr     req
);

    // next burst to be written
    burst_idx_t wr_idx;

    // a word is in flight
    logic busy;
    // command side already taken
    logic cmd_ok;
    // data side already taken
    logic dat_ok;
    // FIFO pop cycle
    logic pop;
    // settle cycle after the pop, empty not trusted yet
    logic gap;

    logic cmd_acc;
    logic dat_acc;
    logic both_done;
    logic start;

    // handshakes of this cycle
    assign cmd_acc   = req.wr_en && req.wr_rdy;
    assign dat_acc   = app_wdf_wren && app_wdf_rdy;

    // both halves of the word are done by the end of this cycle
    assign both_done = busy && (cmd_ok || cmd_acc) && (dat_ok || dat_acc);

    // new word on the FIFO head
    assign start     = acq_enabled && !ddr3_wr_fifo_empty && !busy && !pop && !gap;

    // one beat per burst
    assign app_wdf_end        = app_wdf_wren;
    assign ddr3_wr_fifo_rd_en = pop;
    assign req.wr_addr        = wr_idx;

    // ******************************
    // word sequencing
    // ******************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            cmd_ok       <= 1'b0;
            dat_ok       <= 1'b0;
            pop          <= 1'b0;
            gap          <= 1'b0;
            req.wr_en    <= 1'b0;
            app_wdf_wren <= 1'b0;
            wr_idx       <= '0;
        end else begin
            pop <= both_done;
            gap <= pop;
            if (start) begin
                // command and data go up together
                busy         <= 1'b1;
                cmd_ok       <= 1'b0;
                dat_ok       <= 1'b0;
                req.wr_en    <= 1'b1;
                app_wdf_wren <= 1'b1;
            end else begin
                // each side drops on its own acceptance
                if (cmd_acc) begin
                    req.wr_en <= 1'b0;
                    cmd_ok    <= 1'b1;
                end
                if (dat_acc) begin
                    app_wdf_wren <= 1'b0;
                    dat_ok       <= 1'b1;
                end
                if (both_done) begin
                    busy <= 1'b0;
                end
            end
            // next burst, or back to 0 between acquisitions
            if (both_done) begin
                wr_idx <= wr_idx + 1'b1;
            end else if (!acq_enabled && !busy) begin
                wr_idx <= '0;
            end
        end
    end

    // ******************************
    // write done flag
    // ******************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            ddr3_wr_done <= 1'b0;
        end else if (!acq_enabled) begin
            ddr3_wr_done <= 1'b0;
        end else if (acq_done && ddr3_wr_fifo_empty && !busy && !pop) begin
            // acquisition over and nothing left to drain
            ddr3_wr_done <= 1'b1;
        end
    end

endmodule

// File: source/ddr3_rd_control.sv
module ddr3_rd_control
    import ddr3_ctrl_pkg::*;
(
    input  logic       ddr3_domain_clk,
    input  logic       rst_n,
    input  logic       acq_enabled,
    input  logic       enable_reading,
    input  burst_idx_t ddr3_rd_start_addr,
    input  burst_cnt_t ddr3_rd_burst_cnt,
    input  logic       ddr3_rd_fifo_almost_full,
    app_req_if.rd      req
);

    // next burst to read
    burst_idx_t rd_idx;
    // read commands still to issue
    burst_cnt_t rd_left;

    logic rd_acc;
    logic rd_raise;

    assign rd_acc   = req.rd_en && req.rd_rdy;

    // new request only in readout mode with room downstream
    assign rd_raise = !acq_enabled && !req.rd_en && (rd_left != '0) &&
                      !ddr3_rd_fifo_almost_full;

    assign req.rd_addr = rd_idx;

    // ******************************
    // address and count
    // ******************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            rd_idx  <= '0;
            rd_left <= '0;
        end else if (enable_reading) begin
            // load a new readout
            rd_idx  <= ddr3_rd_start_addr;
            rd_left <= ddr3_rd_burst_cnt;
        end else if (rd_acc) begin
            rd_idx  <= rd_idx + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
    end

    // ******************************
    // request line
    // ******************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            req.rd_en <= 1'b0;
        end else if (rd_acc) begin
            // taken, drop for at least one cycle
            req.rd_en <= 1'b0;
        end else if (rd_raise) begin
            // almost_full only blocks a new request
            // one already raised stays up
            req.rd_en <= 1'b1;
        end
    end

endmodule

// File: source/ddr3_cmd_arbiter.sv
module ddr3_cmd_arbiter
    import ddr3_app_pkg::*;
    import ddr3_ctrl_pkg::*;
(
    input  logic      ddr3_domain_clk,
    input  logic      rst_n,
    input  logic      app_rdy,
    output app_addr_t app_addr,
    output app_cmd_t  app_cmd,
    output logic      app_en,
    app_req_if.arb    req
);

    arb_state_t state;

    // burst index to memory address
    function automatic app_addr_t burst_to_addr(input burst_idx_t idx);
        // rank 0, column bits zero
        return {1'b0, idx, {app_col_w{1'b0}}};
    endfunction

    // command port busy whenever a grant is held
    assign app_en = (state != arb_idle);

    // acceptance goes back to the granted requester only
    assign req.wr_rdy = (state == arb_write) && app_en && app_rdy;
    assign req.rd_rdy = (state == arb_read) && app_en && app_rdy;

    // ******************************
    // grant FSM
    // ******************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin
                    // write first, acquisition must not stall
                    if (req.wr_en) begin
                        state <= arb_write;
                    end else if (req.rd_en) begin
                        state <= arb_read;
                    end
                end
                arb_write, arb_read: begin
                    // hold until the memory takes it
                    if (app_rdy) begin
                        state <= arb_idle;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    // command and address captured with the grant
    always_ff @(posedge ddr3_domain_clk) begin
        if (state == arb_idle) begin
            if (req.wr_en) begin
                app_cmd  <= app_cmd_write;
                app_addr <= burst_to_addr(req.wr_addr);
            end else if (req.rd_en) begin
                app_cmd  <= app_cmd_read;
                app_addr <= burst_to_addr(req.rd_addr);
            end
        end
    end

endmodule

// File: source/ddr3_rd_return.sv
module ddr3_rd_return
    import ddr3_app_pkg::*;
    import ddr3_ctrl_pkg::*;
(
    input  logic       ddr3_domain_clk,
    input  logic       rst_n,
    input  logic       enable_reading,
    input  burst_cnt_t ddr3_rd_burst_cnt,
    input  app_data_t  app_rd_data,
    input  logic       app_rd_data_valid,
    output logic       ddr3_rd_fifo_wr_en,
    output app_data_t  ddr3_rd_fifo_input_dat,
    output logic       ddr3_rd_fifo_input_tlast,
    output logic       reading_done
);

    // beats still expected from the memory
    burst_cnt_t beats_left;

    // ******************************
    // beat counting and flags
    // ******************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            beats_left               <= '0;
            ddr3_rd_fifo_wr_en       <= 1'b0;
            ddr3_rd_fifo_input_tlast <= 1'b0;
            reading_done             <= 1'b0;
        end else begin
            ddr3_rd_fifo_wr_en       <= app_rd_data_valid;
            // last beat of the latched count
            ddr3_rd_fifo_input_tlast <= app_rd_data_valid && (beats_left == 1);
            if (enable_reading) begin
                beats_left <= ddr3_rd_burst_cnt;
            end else if (app_rd_data_valid && (beats_left != '0)) begin
                beats_left <= beats_left - 1'b1;
            end
            // done after the tlast beat, until the next readout
            if (enable_reading) begin
                reading_done <= 1'b0;
            end else if (ddr3_rd_fifo_wr_en && ddr3_rd_fifo_input_tlast) begin
                reading_done <= 1'b1;
            end
        end
    end

    // data follows valid by one cycle
    always_ff @(posedge ddr3_domain_clk) begin
        ddr3_rd_fifo_input_dat <= app_rd_data;
    end

endmodule

// File: source/ddr3_intf.sv
module ddr3_intf
    import ddr3_app_pkg::*;
    import ddr3_ctrl_pkg::*;
(
    input  logic       ddr3_domain_clk,
    input  logic       rst_n,
    // acquisition side
    input  logic       acq_enabled,
    input  logic       acq_done,
    input  logic       ddr3_wr_fifo_empty,
    input  app_data_t  ddr3_wr_fifo_dat,
    output logic       ddr3_wr_fifo_rd_en,
    output logic       ddr3_wr_done,
    // readout control
    input  burst_idx_t ddr3_rd_start_addr,
    input  burst_cnt_t ddr3_rd_burst_cnt,
    input  logic       enable_reading,
    output logic       reading_done,
    // read FIFO
    input  logic       ddr3_rd_fifo_almost_full,
    output logic       ddr3_rd_fifo_wr_en,
    output app_data_t  ddr3_rd_fifo_input_dat,
    output logic       ddr3_rd_fifo_input_tlast,
    // memory user interface
    input  logic       app_rdy,
    input  logic       app_wdf_rdy,
    input  app_data_t  app_rd_data,
    input  logic       app_rd_data_valid,
    output app_addr_t  app_addr,
    output app_cmd_t   app_cmd,
    output logic       app_en,
    output app_data_t  app_wdf_data,
    output logic       app_wdf_wren,
    output logic       app_wdf_end
);

    // requests from both controllers to the arbiter
    app_req_if req_bus ();

    // FIFO head goes straight to the write data port
    assign app_wdf_data = ddr3_wr_fifo_dat;

    // ******************************
    // request generation
    // ******************************

    // acquisition words into consecutive bursts
    ddr3_wr_control u_wr_control (
        .ddr3_domain_clk    (ddr3_domain_clk),
        .rst_n              (rst_n),
        .acq_enabled        (acq_enabled),
        .acq_done           (acq_done),
        .ddr3_wr_fifo_empty (ddr3_wr_fifo_empty),
        .app_wdf_rdy        (app_wdf_rdy),
        .ddr3_wr_fifo_rd_en (ddr3_wr_fifo_rd_en),
        .app_wdf_wren       (app_wdf_wren),
        .app_wdf_end        (app_wdf_end),
        .ddr3_wr_done       (ddr3_wr_done),
        .req                (req_bus.wr)
    );

    // readout commands with back-pressure
    ddr3_rd_control u_rd_control (
        .ddr3_domain_clk          (ddr3_domain_clk),
        .rst_n                    (rst_n),
        .acq_enabled              (acq_enabled),
        .enable_reading           (enable_reading),
        .ddr3_rd_start_addr       (ddr3_rd_start_addr),
        .ddr3_rd_burst_cnt        (ddr3_rd_burst_cnt),
        .ddr3_rd_fifo_almost_full (ddr3_rd_fifo_almost_full),
        .req                      (req_bus.rd)
    );

    // ******************************
    // command issue
    // ******************************
    ddr3_cmd_arbiter u_cmd_arbiter (
        .ddr3_domain_clk (ddr3_domain_clk),
        .rst_n           (rst_n),
        .app_rdy         (app_rdy),
        .app_addr        (app_addr),
        .app_cmd         (app_cmd),
        .app_en          (app_en),
        .req             (req_bus.arb)
    );

    // ******************************
    // read return
    // ******************************
    ddr3_rd_return u_rd_return (
        .ddr3_domain_clk          (ddr3_domain_clk),
        .rst_n                    (rst_n),
        .enable_reading           (enable_reading),
        .ddr3_rd_burst_cnt        (ddr3_rd_burst_cnt),
        .app_rd_data              (app_rd_data),
        .app_rd_data_valid        (app_rd_data_valid),
        .ddr3_rd_fifo_wr_en       (ddr3_rd_fifo_wr_en),
        .ddr3_rd_fifo_input_dat   (ddr3_rd_fifo_input_dat),
        .ddr3_rd_fifo_input_tlast (ddr3_rd_fifo_input_tlast),
        .reading_done             (reading_done)
    );

endmodule

// File: bench/ddr3_mem_model.sv
module ddr3_mem_model
    import ddr3_app_pkg::*;
    import ddr3_ctrl_pkg::*;
(
    input  logic      ddr3_domain_clk,
    input  logic      rst_n,
    input  app_addr_t app_addr,
    input  app_cmd_t  app_cmd,
    input  logic      app_en,
    input  app_data_t app_wdf_data,
    input  logic      app_wdf_wren,
    output logic      app_rdy,
    output logic      app_wdf_rdy,
    output app_data_t app_rd_data,
    output logic      app_rd_data_valid
);

    // 256 bursts of storage and reads above that give the fill word
    app_data_t  mem [0:255];
    // write commands and data beats wait here to be paired
    burst_idx_t wa_q [$];
    app_data_t  wd_q [$];
    // reads in flight with index and return cycle
    burst_idx_t ra_q [$];
    int         rdue_q [$];
    int         cyc;
    int         i;
    int         n;
    burst_idx_t idx;
    logic [31:0] lfsr;
    logic [3:0]  bits;

    // fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // unwritten burst tagged with its full index
    function automatic app_data_t fill_word(input burst_idx_t b);
        return {4{9'h1a5, b}};
    endfunction

    function automatic app_data_t read_word(input burst_idx_t b);
        if (b < 256) begin
            return mem[b[7:0]];
        end
        return fill_word(b);
    endfunction

    initial begin
        lfsr              = 32'h6191_e50d;
        cyc               = 0;
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
        for (i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
    end

    // ******************************
    // accept commands and data
    // ******************************
    always @(negedge ddr3_domain_clk) begin
        if (!rst_n) begin
            wa_q.delete();
            wd_q.delete();
            ra_q.delete();
            rdue_q.delete();
        end else begin
            if (app_en && app_rdy) begin
                // rank and column bits dropped
                if (app_cmd == app_cmd_write) begin
                    wa_q.push_back(app_addr[25:3]);
                end else if (app_cmd == app_cmd_read) begin
                    ra_q.push_back(app_addr[25:3]);
                    // data back three cycles later
                    rdue_q.push_back(cyc + 3);
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wd_q.push_back(app_wdf_data);
            end
            // command and data may arrive in either order
            while (wa_q.size() != 0 && wd_q.size() != 0) begin
                idx = wa_q.pop_front();
                if (idx < 256) begin
                    mem[idx[7:0]] = wd_q.pop_front();
                end else begin
                    wd_q.delete(0);
                end
            end
        end
    end

    // ******************************
    // ready stalls and read return
    // ******************************
    always @(posedge ddr3_domain_clk) begin
        #1;
        cyc++;
        for (n = 0; n < 4; n++) begin
            lfsr    = lfsr_step(lfsr);
            bits[n] = lfsr[0];
        end
        // ready about three cycles in four
        app_rdy           = bits[0] | bits[1];
        app_wdf_rdy       = bits[2] | bits[3];
        app_rd_data_valid = 1'b0;
        if (ra_q.size() != 0 && rdue_q[0] <= cyc) begin
            idx               = ra_q.pop_front();
            rdue_q.delete(0);
            app_rd_data       = read_word(idx);
            app_rd_data_valid = 1'b1;
        end
    end

endmodule

// File: bench/ddr3_intf_tb.sv
module ddr3_intf_tb
    import ddr3_app_pkg::*;
    import ddr3_ctrl_pkg::*;
();

    logic       ddr3_domain_clk;
    logic       rst_n;
    logic       acq_enabled;
    logic       acq_done;
    logic       ddr3_wr_fifo_empty;
    app_data_t  ddr3_wr_fifo_dat;
    logic       ddr3_wr_fifo_rd_en;
    logic       ddr3_wr_done;
    burst_idx_t ddr3_rd_start_addr;
    burst_cnt_t ddr3_rd_burst_cnt;
    logic       enable_reading;
    logic       reading_done;
    logic       ddr3_rd_fifo_almost_full;
    logic       ddr3_rd_fifo_wr_en;
    app_data_t  ddr3_rd_fifo_input_dat;
    logic       ddr3_rd_fifo_input_tlast;
    logic       app_rdy;
    logic       app_wdf_rdy;
    app_data_t  app_rd_data;
    logic       app_rd_data_valid;
    app_addr_t  app_addr;
    app_cmd_t   app_cmd;
    logic       app_en;
    app_data_t  app_wdf_data;
    logic       app_wdf_wren;
    logic       app_wdf_end;

    // one row of the stimulus table
    typedef struct packed {
        logic [31:0] words;
        logic [31:0] base;
        burst_idx_t  rd_start;
        burst_cnt_t  rd_cnt;
        logic        af_on;
        logic [31:0] exp_beats;
        logic [31:0] exp_tlast;
    } test_row_t;

    test_row_t   rows [0:3];
    app_data_t   exp_mem [0:15];
    // write FIFO contents with the FWFT output at the head
    app_data_t   wr_q [$];
    // beats seen on the read FIFO port
    app_data_t   beat_dat [$];
    logic        beat_last [$];
    int          err_count;
    int          fails_before;
    int          tests_run;
    int          tests_failed;
    int          r;
    // 0 idle, 1 acquisition, 2 readout
    int          phase;
    int          cur_words;
    int          cur_start;
    int          cur_cnt;
    logic [31:0] cur_base;
    int          pop_cnt;
    int          wcmd_cnt;
    int          wdat_cnt;
    int          rcmd_cnt;
    int          af_tick;
    logic        pop_req;
    logic        af_mode;
    logic        aborted;
    // almost_full and read grant history
    logic        af_d1;
    logic        af_d2;
    logic        grant_d1;

    ddr3_intf uut (.*);

    ddr3_mem_model u_mem (.*);

    always #4 ddr3_domain_clk = ~ddr3_domain_clk;

    // word k of an acquisition tagged with the row base
    function automatic app_data_t word_value(input logic [31:0] base, input int k);
        logic [31:0] kk;
        kk = k;
        return {base, kk, base ^ kk, ~kk};
    endfunction

    // rank 0, burst index, column zero
    function automatic app_addr_t addr_of(input int idx);
        burst_idx_t b;
        b = idx;
        return {1'b0, b, 3'b000};
    endfunction

    function automatic logic event_seen(input int which);
        case (which)
            0: return ddr3_wr_done;
            1: return !ddr3_wr_done;
            default: return reading_done;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge ddr3_domain_clk);
        #1;
    endtask

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic wait_until(input int which, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (!event_seen(which) && cnt < limit) begin
            next_cycle();
            cnt++;
        end
        if (!event_seen(which)) begin
            $display("timeout at %0t: %s did not happen in %0d cycles", $time, what, limit);
            err_count++;
            aborted = 1'b1;
        end
    endtask

    // ******************************
    // write FIFO and almost_full
    // ******************************
    always @(posedge ddr3_domain_clk) begin
        #2;
        if (pop_req) begin
            pop_req = 1'b0;
            if (wr_q.size() == 0) begin
                $display("error at %0t: write FIFO read while empty", $time);
                err_count++;
            end else begin
                wr_q.delete(0);
            end
        end
        ddr3_wr_fifo_empty = (wr_q.size() == 0);
        ddr3_wr_fifo_dat   = (wr_q.size() != 0) ? wr_q[0] : '0;
        // high three cycles in five
        af_tick++;
        ddr3_rd_fifo_almost_full = af_mode && ((af_tick % 5) < 3);
    end

    // ******************************
    // monitors
    // ******************************
    always @(negedge ddr3_domain_clk) begin
        if (rst_n) begin
            if (ddr3_wr_fifo_rd_en) begin
                pop_cnt++;
                pop_req = 1'b1;
            end
            if (phase == 1 && ddr3_wr_done && pop_cnt < cur_words) begin
                flag_mismatch($sformatf("ddr3_wr_done high after %0d pops", pop_cnt));
            end
            if (app_wdf_end !== app_wdf_wren) begin
                flag_mismatch("app_wdf_end differs from app_wdf_wren");
            end
            if (app_en && app_rdy) begin
                // word k goes to burst k
                if (phase == 1 && (app_cmd !== app_cmd_write ||
                                   app_addr !== addr_of(wcmd_cnt))) begin
                    flag_mismatch($sformatf("write cmd %0d: cmd %0d addr %h",
                                            wcmd_cnt, app_cmd, app_addr));
                end
                if (phase == 2 && (app_cmd !== app_cmd_read ||
                                   app_addr !== addr_of(cur_start + rcmd_cnt))) begin
                    flag_mismatch($sformatf("read cmd %0d: cmd %0d addr %h",
                                            rcmd_cnt, app_cmd, app_addr));
                end
                if (phase == 1) begin
                    wcmd_cnt++;
                end
                if (phase == 2) begin
                    rcmd_cnt++;
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                if (app_wdf_data !== word_value(cur_base, wdat_cnt)) begin
                    flag_mismatch($sformatf("write data %0d is %h", wdat_cnt, app_wdf_data));
                end
                wdat_cnt++;
            end
            if (ddr3_rd_fifo_wr_en) begin
                beat_dat.push_back(ddr3_rd_fifo_input_dat);
                beat_last.push_back(ddr3_rd_fifo_input_tlast);
            end
            if (phase == 2 && reading_done && beat_dat.size() < cur_cnt) begin
                flag_mismatch($sformatf("reading_done after %0d beats", beat_dat.size()));
            end
            // a new read grant needs almost_full low when it was requested
            if (phase == 2 && app_en && app_cmd == app_cmd_read && !grant_d1 && af_d2) begin
                flag_mismatch("read granted although almost_full blocked the request");
            end
            grant_d1 = app_en && (app_cmd == app_cmd_read);
            af_d2    = af_d1;
            af_d1    = ddr3_rd_fifo_almost_full;
        end
    end

    // ******************************
    // acquisition and readout
    // ******************************
    task automatic run_write(input test_row_t row);
        int k;
        cur_words = row.words;
        cur_base  = row.base;
        pop_cnt   = 0;
        wcmd_cnt  = 0;
        wdat_cnt  = 0;
        for (k = 0; k < row.words; k++) begin
            wr_q.push_back(word_value(row.base, k));
        end
        phase = 1;
        next_cycle();
        next_cycle();
        acq_enabled = 1'b1;
        repeat (3) next_cycle();
        acq_done = 1'b1;
        wait_until(0, 2000, "ddr3_wr_done rising");
        if (aborted) begin
            return;
        end
        if (pop_cnt != row.words || wcmd_cnt != row.words || wdat_cnt != row.words ||
            wr_q.size() != 0) begin
            flag_mismatch($sformatf("%0d pops, %0d cmds, %0d beats for %0d words",
                                    pop_cnt, wcmd_cnt, wdat_cnt, row.words));
        end
        for (k = 0; k < row.words; k++) begin
            exp_mem[k] = word_value(row.base, k);
        end
        acq_enabled = 1'b0;
        acq_done    = 1'b0;
        wait_until(1, 20, "ddr3_wr_done clearing");
        phase = 0;
    endtask

    task automatic run_read(input test_row_t row);
        int i;
        cur_start = row.rd_start;
        cur_cnt   = row.rd_cnt;
        rcmd_cnt  = 0;
        beat_dat.delete();
        beat_last.delete();
        af_mode            = row.af_on;
        ddr3_rd_start_addr = row.rd_start;
        ddr3_rd_burst_cnt  = row.rd_cnt;
        enable_reading     = 1'b1;
        next_cycle();
        enable_reading = 1'b0;
        phase          = 2;
        if (reading_done !== 1'b0) begin
            flag_mismatch("reading_done not cleared by enable_reading");
        end
        wait_until(2, 2000, "reading_done rising");
        if (aborted) begin
            return;
        end
        // stray beats would land here
        repeat (8) next_cycle();
        phase   = 0;
        af_mode = 1'b0;
        if (beat_dat.size() != row.exp_beats || rcmd_cnt != row.rd_cnt) begin
            flag_mismatch($sformatf("%0d beats and %0d read cmds, expected %0d",
                                    beat_dat.size(), rcmd_cnt, row.exp_beats));
        end
        for (i = 0; i < beat_dat.size(); i++) begin
            if (beat_dat[i] !== exp_mem[row.rd_start + i]) begin
                flag_mismatch($sformatf("beat %0d is %h", i, beat_dat[i]));
            end
            if (beat_last[i] !== (i == row.exp_tlast)) begin
                flag_mismatch($sformatf("tlast %b on beat %0d", beat_last[i], i));
            end
        end
    endtask

    initial begin
        ddr3_domain_clk          = 1'b0;
        rst_n                    = 1'b0;
        acq_enabled              = 1'b0;
        acq_done                 = 1'b0;
        ddr3_wr_fifo_empty       = 1'b1;
        ddr3_wr_fifo_dat         = '0;
        ddr3_rd_start_addr       = '0;
        ddr3_rd_burst_cnt        = '0;
        enable_reading           = 1'b0;
        ddr3_rd_fifo_almost_full = 1'b0;
        pop_req                  = 1'b0;
        af_mode                  = 1'b0;
        aborted                  = 1'b0;
        phase                    = 0;
        err_count                = 0;
        tests_run                = 0;
        tests_failed             = 0;
        af_tick                  = 0;
        // words, base, read start, read count, almost_full, beats, tlast beat
        rows[0] = {32'd6,  32'ha000_0001, 23'd0, 24'd6, 1'b0, 32'd6, 32'd5};
        rows[1] = {32'd10, 32'hb000_0002, 23'd3, 24'd5, 1'b1, 32'd5, 32'd4};
        rows[2] = {32'd4,  32'hc000_0003, 23'd2, 24'd6, 1'b1, 32'd6, 32'd5};
        rows[3] = {32'd8,  32'hd000_0004, 23'd7, 24'd1, 1'b0, 32'd1, 32'd0};
        repeat (8) next_cycle();
        rst_n = 1'b1;
        @(negedge ddr3_domain_clk);
        tests_run++;
        if ({ddr3_wr_fifo_rd_en, app_en, app_wdf_wren, ddr3_wr_done, ddr3_rd_fifo_wr_en,
             ddr3_rd_fifo_input_tlast, reading_done} !== 7'b0) begin
            flag_mismatch("control outputs not low after reset");
            tests_failed++;
        end
        $display("test reset: %s", (err_count == 0) ? "ok" : "errors");
        for (r = 0; r < 4 && !aborted; r++) begin
            fails_before = err_count;
            tests_run++;
            run_write(rows[r]);
            if (!aborted) begin
                run_read(rows[r]);
            end
            if (err_count != fails_before) begin
                tests_failed++;
            end
            $display("test %0d: %0d words, %0d bursts from %0d, almost_full %b: %s",
                     r, rows[r].words, rows[r].rd_cnt, rows[r].rd_start, rows[r].af_on,
                     (err_count == fails_before) ? "ok" : "errors");
        end
        $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: ddr3_intf.f
source/ddr3_app_pkg.sv
source/ddr3_ctrl_pkg.sv
source/app_req_if.sv
source/ddr3_wr_control.sv
source/ddr3_rd_control.sv
source/ddr3_cmd_arbiter.sv
source/ddr3_rd_return.sv
source/ddr3_intf.sv
bench/ddr3_mem_model.sv
bench/ddr3_intf_tb.sv
